// File: hw/acq_pkg.sv
// shared widths and types for the acquisition path
// sample type, counter and timestamp widths, credit depth

`default_nettype none

package acq_pkg;

  //////////////////////////////////////////////////
  // sample stream
  //////////////////////////////////////////////////

  // ADC sample width
  localparam int unsigned smp_w = 14;

  // signed two's complement sample
  typedef logic signed [smp_w-1:0] smp_t;

  //////////////////////////////////////////////////
  // sequencer counters and time
  //////////////////////////////////////////////////

  // pre/post trigger counters and their limits
  localparam int unsigned cnt_w = 16;

  // free running time counter and stamps
  localparam int unsigned ts_w = 32;

  //////////////////////////////////////////////////
  // output credits
  //////////////////////////////////////////////////

  // credits granted by the downstream buffer after reset
  localparam int unsigned crd_num = 4;

  // credit counter, holds 0 up to crd_num
  localparam int unsigned crd_w = 3;

endpackage

`default_nettype wire

// File: hw/acq_seq.sv
// acquisition sequencer, the execute stage
// start/trigger/stop control with pre and post trigger counters
// free running time counter and event timestamps, interrupts

`default_nettype none

module acq_seq (
  input  wire logic                       sti,
  input  wire logic                       ctl_rst,
  // decoded stream
  input  wire logic                       dec_vld,
  input  wire acq_pkg::smp_t              dec_dat,
  input  wire logic                       dec_lst,
  input  wire logic                       dec_hit,
  // mode
  input  wire logic                       cfg_ten,
  input  wire logic                       cfg_con,
  input  wire logic                       cfg_aut,
  // window lengths
  input  wire logic [acq_pkg::cnt_w-1:0]  cfg_pre,
  input  wire logic [acq_pkg::cnt_w-1:0]  cfg_pst,
  // controls
  input  wire logic                       ctl_acq,
  input  wire logic                       ctl_trg,
  input  wire logic                       ctl_stp,
  // execute stream
  output logic                            exe_vld,
  output acq_pkg::smp_t                   exe_dat,
  output logic                            exe_lst,
  // interrupts
  output logic                            irq_trg,
  output logic                            irq_stp,
  // status
  output logic                            sts_acq,
  output logic                            sts_trg,
  output logic [acq_pkg::cnt_w-1:0]       sts_pre,
  output logic [acq_pkg::cnt_w-1:0]       sts_pst,
  // timestamps
  output logic [acq_pkg::ts_w-1:0]        cts_acq,
  output logic [acq_pkg::ts_w-1:0]        cts_trg,
  output logic [acq_pkg::ts_w-1:0]        cts_stp
);

  import acq_pkg::*;

  // pre window done, trigger allowed
  logic ena_pre;

  logic [cnt_w-1:0] nxt_pre;
  logic [cnt_w-1:0] nxt_pst;
  logic             end_pre;
  logic             end_pst;

  logic trg;
  logic stp;

  // free running time
  logic [ts_w-1:0] tim;

  //////////////////////////////////////////////////
  // event decode
  //////////////////////////////////////////////////

  assign nxt_pre = sts_pre + 1'b1;
  assign nxt_pst = sts_pst + 1'b1;

  // counter ends, qualified by an accepted beat
  assign end_pre = sts_acq & ~sts_trg & ~ena_pre & dec_vld & (nxt_pre == cfg_pre);
  assign end_pst = sts_acq & sts_trg & dec_vld & (nxt_pst == cfg_pst);

  // gated until the pre window is full
  assign trg = sts_acq & ~sts_trg & ena_pre
             & ((dec_vld & dec_hit & cfg_ten) | ctl_trg);

  // manual stop, post window end or input frame end
  assign stp = sts_acq & (ctl_stp
                        | (end_pst & ~cfg_con)
                        | (dec_vld & dec_lst));

  assign irq_trg = trg;
  assign irq_stp = stp;

  //////////////////////////////////////////////////
  // time counter
  //////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      tim <= '0;
    end else begin
      tim <= tim + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // sequencer state and counters
  //////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      sts_acq <= 1'b0;
      sts_trg <= 1'b0;
      ena_pre <= 1'b0;
      sts_pre <= '0;
      sts_pst <= '0;
      cts_acq <= '0;
      cts_trg <= '0;
      cts_stp <= '0;
    end else begin
      // stop wins over a new start
      if (stp) begin
        sts_acq <= 1'b0;
        cts_stp <= tim;
      end else if (ctl_acq) begin
        sts_acq <= 1'b1;
        cts_acq <= tim;
        sts_trg <= cfg_aut;
        // empty pre window arms at once
        ena_pre <= (cfg_pre == '0);
        sts_pre <= '0;
        sts_pst <= '0;
        if (cfg_aut) begin
          cts_trg <= tim;
        end
      end
      if (end_pre) begin
        ena_pre <= 1'b1;
      end
      if (trg) begin
        sts_trg <= 1'b1;
        cts_trg <= tim;
      end
      // pre counter holds at cfg_pre once full
      if (sts_acq & dec_vld & ~sts_trg & ~ena_pre) begin
        sts_pre <= nxt_pre;
      end
      if (sts_acq & dec_vld & sts_trg) begin
        sts_pst <= nxt_pst;
      end
    end
  end

  //////////////////////////////////////////////////
  // execute stream
  //////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      exe_vld <= 1'b0;
      exe_lst <= 1'b0;
    end else begin
      exe_vld <= sts_acq & dec_vld;
      // last beat is the one accepted with the stop
      exe_lst <= dec_vld & stp;
    end
  end

  always_ff @(posedge sti) begin
    if (dec_vld) begin
      exe_dat <= dec_dat;
    end
  end

endmodule

`default_nettype wire

// File: hw/acq_top.sv
// acquisition path top level
// edge decode, sequencer and credit output stage in a row

`default_nettype none

module acq_top (
  input  wire logic                       sti,
  input  wire logic                       ctl_rst,
  // ADC stream
  input  wire logic                       smp_vld,
  input  wire acq_pkg::smp_t              smp_dat,
  input  wire logic                       smp_lst,
  // trigger setup
  input  wire acq_pkg::smp_t              cfg_lvl,
  input  wire logic                       cfg_neg,
  input  wire logic                       cfg_ten,
  // sequencer setup
  input  wire logic                       cfg_con,
  input  wire logic                       cfg_aut,
  input  wire logic [acq_pkg::cnt_w-1:0]  cfg_pre,
  input  wire logic [acq_pkg::cnt_w-1:0]  cfg_pst,
  // controls
  input  wire logic                       ctl_acq,
  input  wire logic                       ctl_trg,
  input  wire logic                       ctl_stp,
  // downstream buffer
  input  wire logic                       crd_ret,
  output logic                            out_vld,
  output acq_pkg::smp_t                   out_dat,
  output logic                            out_lst,
  // interrupts and status
  output logic                            irq_trg,
  output logic                            irq_stp,
  output logic                            sts_acq,
  output logic                            sts_trg,
  output logic [acq_pkg::cnt_w-1:0]       sts_pre,
  output logic [acq_pkg::cnt_w-1:0]       sts_pst,
  output logic                            sts_ovf,
  output logic [acq_pkg::ts_w-1:0]        cts_acq,
  output logic [acq_pkg::ts_w-1:0]        cts_trg,
  output logic [acq_pkg::ts_w-1:0]        cts_stp
);

  import acq_pkg::*;

  // decode to execute
  logic dec_vld;
  smp_t dec_dat;
  logic dec_lst;
  logic dec_hit;

  // execute to result
  logic exe_vld;
  smp_t exe_dat;
  logic exe_lst;

  trg_edge u_dec (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .smp_vld (smp_vld),
    .smp_dat (smp_dat),
    .smp_lst (smp_lst),
    .cfg_lvl (cfg_lvl),
    .cfg_neg (cfg_neg),
    .dec_vld (dec_vld),
    .dec_dat (dec_dat),
    .dec_lst (dec_lst),
    .dec_hit (dec_hit)
  );

  acq_seq u_exe (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .dec_vld (dec_vld),
    .dec_dat (dec_dat),
    .dec_lst (dec_lst),
    .dec_hit (dec_hit),
    .cfg_ten (cfg_ten),
    .cfg_con (cfg_con),
    .cfg_aut (cfg_aut),
    .cfg_pre (cfg_pre),
    .cfg_pst (cfg_pst),
    .ctl_acq (ctl_acq),
    .ctl_trg (ctl_trg),
    .ctl_stp (ctl_stp),
    .exe_vld (exe_vld),
    .exe_dat (exe_dat),
    .exe_lst (exe_lst),
    .irq_trg (irq_trg),
    .irq_stp (irq_stp),
    .sts_acq (sts_acq),
    .sts_trg (sts_trg),
    .sts_pre (sts_pre),
    .sts_pst (sts_pst),
    .cts_acq (cts_acq),
    .cts_trg (cts_trg),
    .cts_stp (cts_stp)
  );

  crd_out u_res (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .ctl_acq (ctl_acq),
    .exe_vld (exe_vld),
    .exe_dat (exe_dat),
    .exe_lst (exe_lst),
    .crd_ret (crd_ret),
    .out_vld (out_vld),
    .out_dat (out_dat),
    .out_lst (out_lst),
    .sts_ovf (sts_ovf)
  );

endmodule

`default_nettype wire

// File: hw/crd_out.sv
// credit based output stage, the result stage
// output register, credit counter and sticky overflow flag

`default_nettype none

module crd_out (
  input  wire logic          sti,
  input  wire logic          ctl_rst,
  input  wire logic          ctl_acq,
  // execute stream
  input  wire logic          exe_vld,
  input  wire acq_pkg::smp_t exe_dat,
  input  wire logic          exe_lst,
  // one pulse per freed downstream entry
  input  wire logic          crd_ret,
  // output stream
  output logic               out_vld,
  output acq_pkg::smp_t      out_dat,
  output logic               out_lst,
  output logic               sts_ovf
);

  import acq_pkg::*;

  localparam logic [crd_w-1:0] crd_max = crd_w'(crd_num);

  logic [crd_w-1:0] crd_cnt;
  logic             snd;
  logic             drp;

  // send only with a credit in hand
  assign snd = exe_vld & (crd_cnt != '0);
  // ADC cannot stall, the beat is lost
  assign drp = exe_vld & ~snd;

  //////////////////////////////////////////////////
  // credit counter
  //////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      crd_cnt <= crd_max;
    end else begin
      // send and return together leave it unchanged
      if (snd & ~crd_ret) begin
        crd_cnt <= crd_cnt - 1'b1;
      end else if (~snd & crd_ret & (crd_cnt < crd_max)) begin
        crd_cnt <= crd_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // output register and overflow
  //////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      out_vld <= 1'b0;
      out_lst <= 1'b0;
      sts_ovf <= 1'b0;
    end else begin
      out_vld <= snd;
      out_lst <= snd & exe_lst;
      // sticky until the next start
      if (drp) begin
        sts_ovf <= 1'b1;
      end else if (ctl_acq) begin
        sts_ovf <= 1'b0;
      end
    end
  end

  always_ff @(posedge sti) begin
    if (snd) begin
      out_dat <= exe_dat;
    end
  end

endmodule

`default_nettype wire

// File: hw/trg_edge.sv
// edge trigger decode stage
// registers the sample stream and flags level crossings

`default_nettype none

module trg_edge (
  input  wire logic          sti,
  input  wire logic          ctl_rst,
  // sample stream from the ADC
  input  wire logic          smp_vld,
  input  wire acq_pkg::smp_t smp_dat,
  input  wire logic          smp_lst,
  // trigger level and direction
  input  wire acq_pkg::smp_t cfg_lvl,
  input  wire logic          cfg_neg,
  // decoded stream
  output logic               dec_vld,
  output acq_pkg::smp_t      dec_dat,
  output logic               dec_lst,
  output logic               dec_hit
);

  import acq_pkg::*;

  // previous valid sample and its presence
  smp_t prv_dat;
  logic prv_ok;

  logic hit_rise;
  logic hit_fall;
  logic hit;

  //////////////////////////////////////////////////
  // crossing detect
  //////////////////////////////////////////////////

  // rising: below the level, then at or above it
  assign hit_rise = (prv_dat < cfg_lvl) && (smp_dat >= cfg_lvl);
  // falling mirror
  assign hit_fall = (prv_dat > cfg_lvl) && (smp_dat <= cfg_lvl);

  // first sample after reset has nothing to compare with
  assign hit = smp_vld & prv_ok & (cfg_neg ? hit_fall : hit_rise);

  //////////////////////////////////////////////////
  // pipeline register
  //////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      dec_vld <= 1'b0;
      dec_lst <= 1'b0;
      dec_hit <= 1'b0;
      prv_ok  <= 1'b0;
    end else begin
      dec_vld <= smp_vld;
      dec_lst <= smp_vld & smp_lst;
      dec_hit <= hit;
      if (smp_vld) begin
        prv_ok <= 1'b1;
      end
    end
  end

  // payload, no reset
  always_ff @(posedge sti) begin
    if (smp_vld) begin
      dec_dat <= smp_dat;
      prv_dat <= smp_dat;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module acq_tb -f sim.f -o acq_sim &&
./obj_dir/acq_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "run passed" ||
{ echo "run failed"; exit 1; }

// File: sim.f
hw/acq_pkg.sv
hw/trg_edge.sv
hw/acq_seq.sv
hw/crd_out.sv
hw/acq_top.sv
sim/acq_props.sv
sim/acq_tb.sv

// File: sim/acq_props.sv
// concurrent checks bound into the acquisition top level
// credit limit and the three cycle sample to output latency

`default_nettype none

module acq_props (
  input wire logic          sti,
  input wire logic          ctl_rst,
  input wire logic          smp_vld,
  input wire acq_pkg::smp_t smp_dat,
  input wire logic          out_vld,
  input wire acq_pkg::smp_t out_dat,
  input wire logic          crd_ret
);

  import acq_pkg::*;

  // beats sent and not yet returned
  int osd;

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      osd <= 0;
    end else begin
      osd <= osd + int'(out_vld) - int'(crd_ret);
    end
  end

  crd_limit: assert property (@(posedge sti) disable iff (ctl_rst) osd <= int'(crd_num))
    else $error("outstanding beats above the credit limit");

  lat_vld: assert property (@(posedge sti) disable iff (ctl_rst) out_vld |-> $past(smp_vld, 3))
    else $error("out beat without a sample three cycles before");

  lat_dat: assert property (@(posedge sti) disable iff (ctl_rst)
                            out_vld |-> out_dat == $past(smp_dat, 3))
    else $error("out_dat differs from the sample three cycles before");

endmodule

bind acq_top acq_props u_props (.*);

`default_nettype wire

// File: sim/acq_tb.sv
// testbench for the acquisition path
// clock, reset, sample stimulus, downstream credit model
// scoreboard counters, per-test report and timeout

`default_nettype none

module acq_tb;

  import acq_pkg::*;

  // longest test with drain and credit release, plus reset and margin
  localparam int test_len = 40;
  localparam int n_tests  = 6;
  localparam int max_cyc  = 10 + n_tests * test_len + 60;

  logic             sti, ctl_rst, smp_vld, smp_lst, cfg_neg, cfg_ten, cfg_con, cfg_aut;
  logic             ctl_acq, ctl_trg, ctl_stp, crd_ret;
  smp_t             smp_dat, cfg_lvl, out_dat;
  logic [cnt_w-1:0] cfg_pre, cfg_pst, sts_pre, sts_pst;
  logic             out_vld, out_lst, irq_trg, irq_stp, sts_acq, sts_trg, sts_ovf;
  logic [ts_w-1:0]  cts_acq, cts_trg, cts_stp;

  // test setup, beat indices count from the ctl_acq cycle, -1 is unused
  int c_pre, c_pst, hit_a, hit_b, trg_at, stp_at, lst_at, exp_trg, exp_stp;
  bit c_aut, c_con, c_ten, ret_hold;

  // scoreboard
  int   seed = 32'hc780fbdd;
  int   cyc, acq_cyc, trg_cyc, stp_cyc, pre_at_trg;
  int   acc, outs, lsts, trgs, errs, n_run, n_bad, ret_dly;
  bit   last_lst, p_vld;
  smp_t p_dat;
  smp_t exp_q[$];
  int   due[$];
  string test_name;

  acq_top uut (.*);

  initial begin
    sti = 1'b0;
    forever #10 sti = ~sti;
  end

  function automatic smp_t sample_at(int i);
    // crossings of level zero only where placed
    if (i == hit_a || i == hit_b) return smp_t'(500);
    return smp_t'(-(($random(seed) & 1023) + 1));
  endfunction

  task automatic expect_eq(string what, longint exp, longint act);
    assert (exp == act) else begin
      $display("error %s %s expected %0d actual %0d", test_name, what, exp, act);
      errs++;
    end
  endtask

  ////////////////////////////////////////////////////
  // monitor and downstream credit model
  ////////////////////////////////////////////////////

  always @(posedge sti) begin
    if (!ctl_rst) begin
      if (ctl_acq) acq_cyc = cyc;
      // beat one cycle old is the one the sequencer sees
      if (sts_acq && p_vld) begin
        exp_q.push_back(p_dat);
        acc++;
      end
      if (out_vld) begin
        outs++;
        last_lst = out_lst;
        if (out_lst) lsts++;
        if (exp_q.size() == 0) begin
          $display("error %s out beat with no accepted sample", test_name);
          errs++;
        end else begin
          expect_eq("out_dat", exp_q.pop_front(), out_dat);
        end
        due.push_back(cyc + ret_dly);
      end
      if (irq_trg) begin
        trg_cyc = cyc;
        pre_at_trg = sts_pre;
        trgs++;
      end
      if (irq_stp) stp_cyc = cyc;
      crd_ret <= 1'b0;
      if (!ret_hold && due.size() != 0 && due[0] <= cyc) begin
        void'(due.pop_front());
        crd_ret <= 1'b1;
      end
    end
    p_vld = smp_vld;
    p_dat = smp_dat;
    cyc = cyc + 1;
    if (cyc >= max_cyc) begin
      $display("timeout, the run did not finish within %0d cycles", max_cyc);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // frame end beat is the last one out
  lst_ends_frame: assert property (@(posedge sti) disable iff (ctl_rst) out_lst |=> !out_vld)
    else begin
      $display("an out beat followed the frame end beat");
      errs++;
    end

  ////////////////////////////////////////////////////
  // one capture from ctl_acq to stop
  ////////////////////////////////////////////////////

  task automatic capture(string name);
    int i;
    int errs0;
    bit stopped;
    bit trg_done;
    test_name = name;
    errs0 = errs;
    i = 0;
    stopped = 0;
    trg_done = 0;
    {acc, outs, lsts, trgs, last_lst} = '0;
    exp_q.delete();
    cfg_pre <= cnt_w'(c_pre);
    cfg_pst <= cnt_w'(c_pst);
    {cfg_aut, cfg_con, cfg_ten} <= {c_aut, c_con, c_ten};
    while (!stopped) begin
      ctl_acq <= (i == 0);
      smp_vld <= 1'b1;
      smp_dat <= sample_at(i);
      smp_lst <= (i == lst_at);
      ctl_stp <= (i == stp_at);
      ctl_trg <= (trg_at >= 0) && (i >= trg_at) && !trg_done;
      @(posedge sti);
      if (irq_trg) trg_done = 1;
      if (c_aut && i > 0) begin
        expect_eq("sts_trg", 1, sts_trg);
        expect_eq("sts_pre", 0, sts_pre);
      end
      stopped = irq_stp;
      i++;
    end
    {smp_vld, smp_lst, ctl_stp, ctl_trg, ctl_acq} <= '0;
    // three register stages to drain
    repeat (4) @(posedge sti);
    expect_eq("triggers", (exp_trg >= 0) ? 1 : 0, trgs);
    if (exp_trg >= 0) begin
      expect_eq("trg cycle", exp_trg, trg_cyc - acq_cyc);
      expect_eq("trg stamp", trg_cyc - acq_cyc, cts_trg - cts_acq);
      expect_eq("pre at trg", c_pre, pre_at_trg);
    end
    expect_eq("stp cycle", exp_stp, stp_cyc - acq_cyc);
    expect_eq("stp stamp", stp_cyc - acq_cyc, cts_stp - cts_acq);
    expect_eq("accepted", exp_stp, acc);
    // beats after the trigger beat up to and including the stop beat
    expect_eq("sts_pst", exp_stp - ((exp_trg >= 0) ? exp_trg : 0), sts_pst);
    if (ret_hold) begin
      expect_eq("out beats", crd_num, outs);
      expect_eq("sts_ovf", 1, sts_ovf);
    end else begin
      expect_eq("out beats", acc, outs);
      expect_eq("out_lst count", 1, lsts);
      expect_eq("last out_lst", 1, last_lst);
      expect_eq("sts_ovf", 0, sts_ovf);
    end
    n_run++;
    if (errs != errs0) n_bad++;
    if (errs == errs0) $display("test %s ok", name);
    else $display("test %s had %0d errors", name, errs - errs0);
  endtask

  task automatic setup(int pre, int pst, bit aut, bit con, bit ten, int ha, int hb,
                       int ta, int sa, int la, int et, int es);
    {c_pre, c_pst, c_aut, c_con, c_ten} = {pre, pst, aut, con, ten};
    {hit_a, hit_b, trg_at, stp_at, lst_at} = {ha, hb, ta, sa, la};
    exp_trg = et;
    exp_stp = es;
  endtask

  initial begin
    {ctl_rst, smp_vld, smp_lst, cfg_neg, cfg_ten, cfg_con, cfg_aut} = 7'b1000000;
    {ctl_acq, ctl_trg, ctl_stp, crd_ret} = '0;
    {smp_dat, cfg_lvl, cfg_pre, cfg_pst} = '0;
    {cyc, errs, n_run, n_bad, ret_dly, ret_hold} = '0;
    repeat (10) @(posedge sti);
    ctl_rst <= 1'b0;
    @(posedge sti);
    // early crossing gated, second one triggers, post window stops
    setup(8, 6, 0, 0, 1, 6, 11, -1, -1, -1, 12, 18);
    capture("pregate");
    // downstream frees each entry a cycle later from here on
    ret_dly = 1;
    // ctl_trg held until the pre window allows it, ctl_stp ends
    setup(4, 50, 0, 0, 0, -1, -1, 1, 12, -1, 5, 12);
    capture("manual");
    // auto trigger, continuous run past the post window
    setup(5, 3, 1, 1, 0, -1, -1, -1, 20, -1, -1, 20);
    capture("autocon");
    // input frame end stops the run
    setup(2, 40, 0, 0, 1, 4, -1, -1, -1, 9, 5, 10);
    capture("lstin");
    // downstream withholds credits
    ret_hold = 1;
    setup(0, 50, 1, 0, 0, -1, -1, -1, 20, -1, -1, 20);
    capture("credit");
    ret_hold = 0;
    while (due.size() != 0) @(posedge sti);
    repeat (2) @(posedge sti);
    // new start clears the overflow flag
    setup(0, 50, 1, 0, 0, -1, -1, -1, 6, -1, -1, 6);
    capture("ovfclr");
    $display("tests %0d, failed %0d, errors %0d", n_run, n_bad, errs);
    if (errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
